//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := branch_subsystem_tb
FILELIST := list.f

.PHONY: sim clean

# Build, run, and pass only when the output holds the pass line.
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- bench/branch_subsystem_props.sv
`timescale 1ns/1ps

module branch_subsystem_props (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      result_valid,
    input logic                      result_ready,
    input ppc_types::branch_result_t result,
    input logic                      speculative,
    input logic                      clear_speculative,
    input logic                      flush_speculative,
    input logic                      illegal_instr
);

    // --------------------------------------------------
    // Result handshake
    // --------------------------------------------------

    // A stalled result keeps its valid and its payload.
    result_held: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else $error("result changed while result_ready was low");

    // --------------------------------------------------
    // Speculation and illegal pulses
    // --------------------------------------------------

    // A branch is either confirmed or flushed, never both.
    pulses_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear_speculative && flush_speculative))
        else $error("clear_speculative and flush_speculative high together");

    // Pulses only on the handoff of a conditional result.
    pulse_on_handoff: assert property (@(posedge clk) disable iff (!rst_n)
        clear_speculative || flush_speculative
        |-> result_valid && result_ready && speculative)
        else $error("speculation pulse outside a conditional handoff");

    // Each dropped word gives a single-cycle pulse.
    illegal_single: assert property (@(posedge clk) disable iff (!rst_n)
        illegal_instr |=> !illegal_instr)
        else $error("illegal_instr high for more than one cycle");

endmodule

//--- bench/branch_subsystem_tb.sv
`timescale 1ns/1ps

module branch_subsystem_tb;
    import ppc_types::*;

    // Expected result plus whether the branch was conditional.
    typedef struct packed {
        branch_result_t res;
        logic           cond;
    } expected_t;

    localparam int WAIT_LIMIT = 200;

    logic           clk;
    logic           rst_n;
    logic           instr_valid;
    logic           instr_ready;
    logic [31:0]    instr;
    logic [31:0]    cia;
    logic [31:0]    cr;
    logic [31:0]    lr;
    logic [31:0]    ctr;
    logic           result_valid;
    logic           result_ready;
    branch_result_t result;
    logic           speculative;
    logic           clear_speculative;
    logic           flush_speculative;
    logic           illegal_instr;

    expected_t expected_q[$];
    int        check_idx = 0;
    int        illegal_count = 0;
    int        monitor_errors = 0;
    int        check_errors;
    int        timeout_errors;
    // Consumer behavior: 0 always ready, 1 random, 2 stalled.
    int        ready_mode;

    branch_subsystem i_branch_subsystem (.*);

    bind branch_subsystem branch_subsystem_props i_branch_subsystem_props (
        .clk               (clk),
        .rst_n             (rst_n),
        .result_valid      (result_valid),
        .result_ready      (result_ready),
        .result            (result),
        .speculative       (speculative),
        .clear_speculative (clear_speculative),
        .flush_speculative (flush_speculative),
        .illegal_instr     (illegal_instr)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Result consumer, updated on the falling edge.
    initial
    begin
        logic [31:0] rnd;
        result_ready = 1'b1;
        forever
        begin
            @(negedge clk);
            rnd          = $urandom;
            result_ready = (ready_mode == 0) || ((ready_mode == 1) && rnd[0]);
        end
    end

    // --------------------------------------------------
    // Word encoders and reference model
    // --------------------------------------------------

    function automatic logic [31:0] b_word(logic [23:0] li, logic aa, logic lk);
        b_word = {OP_B, li, aa, lk};
    endfunction

    function automatic logic [31:0] bc_word(logic [4:0] bo, logic [4:0] bi, logic [13:0] bd,
                                            logic aa, logic lk);
        bc_word = {OP_BC, bo, bi, bd, aa, lk};
    endfunction

    function automatic logic [31:0] bclr_word(logic [4:0] bo, logic [4:0] bi, logic lk);
        bclr_word = {OP_XL, bo, bi, 5'b00000, XO_BCLR, lk};
    endfunction

    function automatic logic [31:0] bcctr_word(logic [4:0] bo, logic [4:0] bi, logic lk);
        bcctr_word = {OP_XL, bo, bi, 5'b00000, XO_BCCTR, lk};
    endfunction

    // Little-endian view here, so BO bit 0 is bo[4] and CR bit n is crv[31-n].
    function automatic expected_t expected_result(logic [31:0] word, logic [31:0] pc,
                                                  logic [31:0] crv, logic [31:0] lrv,
                                                  logic [31:0] ctrv);
        expected_t   e;
        logic [4:0]  bo;
        logic [4:0]  bi;
        logic [31:0] base;
        logic [31:0] target;
        logic [31:0] count;
        logic        is_ctr;
        logic        taken;
        bo     = word[25:21];
        bi     = word[20:16];
        base   = word[1] ? 32'h0 : pc;
        count  = ctrv;
        is_ctr = (word[31:26] == OP_XL) && (word[10:1] == XO_BCCTR);
        if (word[31:26] == OP_B)
        begin
            target = base + {{6{word[25]}}, word[25:2], 2'b00};
            taken  = 1'b1;
            e.cond = 1'b0;
        end
        else
        begin
            if (!bo[2] && !is_ctr)
            begin
                count = ctrv - 32'd1;
            end
            // Count test and condition test must both pass.
            taken  = (bo[2] || ((count != 32'h0) != bo[1]))
                  && (bo[4] || (crv[5'd31 - bi] == bo[3]));
            e.cond = 1'b1;
            if (word[31:26] == OP_BC)
                target = base + {{16{word[15]}}, word[15:2], 2'b00};
            else if (is_ctr)
                target = {ctrv[31:2], 2'b00};
            else
                target = {lrv[31:2], 2'b00};
        end
        e.res.nia       = taken ? target : pc + 32'd4;
        e.res.link_reg  = word[0] ? pc + 32'd4 : lrv;
        e.res.count_reg = count;
        e.res.taken     = taken;
        return e;
    endfunction

    // --------------------------------------------------
    // Monitor
    // --------------------------------------------------

    task automatic compare_field(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp == act)
        else
        begin
            $display("ERROR %s expected %08h actual %08h", name, exp, act);
            monitor_errors++;
        end
    endtask

    always @(posedge clk)
    begin
        expected_t e;
        if (rst_n)
        begin
            if (illegal_instr)
                illegal_count++;
            if (!result_valid)
                compare_field("speculative", 32'h0, {31'h0, speculative});
            if (result_valid && result_ready)
            begin
                assert (check_idx < expected_q.size())
                else
                begin
                    $display("A result was handed off with no branch outstanding.");
                    monitor_errors++;
                end
                if (check_idx < expected_q.size())
                begin
                    e = expected_q[check_idx];
                    check_idx++;
                    compare_field("nia", e.res.nia, result.nia);
                    compare_field("link_reg", e.res.link_reg, result.link_reg);
                    compare_field("count_reg", e.res.count_reg, result.count_reg);
                    compare_field("taken", {31'h0, e.res.taken}, {31'h0, result.taken});
                    compare_field("speculative", {31'h0, e.cond}, {31'h0, speculative});
                    compare_field("clear_speculative", {31'h0, e.cond && !e.res.taken},
                                  {31'h0, clear_speculative});
                    compare_field("flush_speculative", {31'h0, e.cond && e.res.taken},
                                  {31'h0, flush_speculative});
                end
            end
        end
    end

    // --------------------------------------------------
    // Drivers and waits
    // --------------------------------------------------

    // Called on a falling edge; returns on a falling edge.
    task automatic send_instr(logic [31:0] word, logic [31:0] pc, logic [31:0] crv,
                              logic [31:0] lrv, logic [31:0] ctrv, logic legal);
        int waited;
        instr_valid = 1'b1;
        instr       = word;
        cia         = pc;
        cr          = crv;
        lr          = lrv;
        ctr         = ctrv;
        waited      = 0;
        while (!instr_ready && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (instr_ready)
        begin
            if (legal)
                expected_q.push_back(expected_result(word, pc, crv, lrv, ctrv));
        end
        else
        begin
            $display("Timed out waiting for instr_ready to accept a word.");
            timeout_errors++;
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((check_idx != expected_q.size() || result_valid) && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (check_idx != expected_q.size() || result_valid)
        begin
            $display("Timed out waiting for the outstanding results.");
            timeout_errors++;
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic wait_illegal(int target);
        int waited;
        waited = 0;
        while (illegal_count < target && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (illegal_count < target)
        begin
            $display("Timed out waiting for illegal_instr pulses.");
            timeout_errors++;
        end
    endtask

    task automatic wait_for_stall();
        int waited;
        waited = 0;
        while (instr_ready && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        assert (!instr_ready)
        else
        begin
            $display("instr_ready never fell while the output was stalled.");
            check_errors++;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (instr_ready && !result_valid && !speculative && !clear_speculative
                && !flush_speculative && !illegal_instr)
        else
        begin
            $display("Outputs are not at their reset values after reset.");
            check_errors++;
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic unconditional_branches();
        send_instr(b_word(24'd100, 1'b0, 1'b0), 32'h1000, 32'h0, 32'h40, 32'h5, 1'b1);
        send_instr(b_word(24'h000400, 1'b1, 1'b1), 32'h2000, 32'h0, 32'h80, 32'h6, 1'b1);
        send_instr(b_word(24'hFFFFF0, 1'b0, 1'b1), 32'h3000, 32'h0, 32'h90, 32'h7, 1'b1);
        send_instr(b_word(24'h800000, 1'b0, 1'b0), 32'h8000_0000, 32'h0, 32'h0, 32'h0, 1'b1);
        wait_drain();
    endtask

    task automatic conditional_branches();
        logic [31:0] crv;
        logic [31:0] ctrv;
        logic [4:0]  bo;
        logic [4:0]  bi;
        // Every condition polarity, count ignored.
        for (int i = 0; i < 8; i++)
        begin
            bo  = {i[2], i[1], 3'b100};
            bi  = 5'(i * 3 + 2);
            crv = $urandom;
            crv[5'd31 - bi] = i[0];
            send_instr(bc_word(bo, bi, i[1] ? 14'h3FF8 : 14'h0010, 1'b0, i[0]),
                       32'h4000, crv, 32'h1111, 32'h3, 1'b1);
        end
        // Decrement with zero and nonzero tests, including a count of 1.
        for (int i = 0; i < 6; i++)
        begin
            bo   = {3'b100, i[0], 1'b0};
            ctrv = (i < 4) ? 32'(i / 2 + 1) : 32'h0;
            send_instr(bc_word(bo, 5'd0, 14'h0020, 1'b0, 1'b0), 32'h5000, 32'h0,
                       32'h2222, ctrv, 1'b1);
        end
        // Count and condition together.
        send_instr(bc_word(5'b00000, 5'd4, 14'h0040, 1'b1, 1'b0), 32'h5100, 32'h0,
                   32'h0, 32'h4, 1'b1);
        send_instr(bc_word(5'b00000, 5'd4, 14'h0040, 1'b1, 1'b0), 32'h5104, 32'h0,
                   32'h0, 32'h1, 1'b1);
        wait_drain();
    endtask

    task automatic register_targets();
        send_instr(bclr_word(5'b10100, 5'd0, 1'b0), 32'h6000, 32'h0, 32'h4000_1237, 32'h9, 1'b1);
        send_instr(bclr_word(5'b10100, 5'd0, 1'b1), 32'h6004, 32'h0, 32'h4000_2003, 32'h9, 1'b1);
        send_instr(bclr_word(5'b10000, 5'd0, 1'b0), 32'h6008, 32'h0, 32'h7001, 32'h5, 1'b1);
        send_instr(bclr_word(5'b00100, 5'd2, 1'b0), 32'h6010, 32'h2000_0000, 32'h7002, 32'h5,
                   1'b1);
        send_instr(bcctr_word(5'b10100, 5'd0, 1'b1), 32'h7000, 32'h0, 32'h33, 32'h8ABF, 1'b1);
        send_instr(bcctr_word(5'b01100, 5'd31, 1'b0), 32'h7004, 32'h1, 32'h33, 32'h1234_5676,
                   1'b1);
        wait_drain();
    endtask

    // Idle cycles keep the illegal pulses apart.
    task automatic illegal_words();
        int start_count;
        start_count = illegal_count;
        send_instr(32'h7C00_0214, 32'h8000, 32'h0, 32'h0, 32'h0, 1'b0);
        @(negedge clk);
        send_instr(32'h3860_0001, 32'h8004, 32'h0, 32'h0, 32'h0, 1'b0);
        @(negedge clk);
        send_instr(bcctr_word(5'b00000, 5'd0, 1'b0), 32'h8008, 32'h0, 32'h0, 32'h7, 1'b0);
        @(negedge clk);
        send_instr({OP_XL, 26'h0}, 32'h800C, 32'h0, 32'h0, 32'h0, 1'b0);
        wait_illegal(start_count + 4);
        send_instr(b_word(24'd8, 1'b0, 1'b1), 32'h8010, 32'h0, 32'h0, 32'h0, 1'b1);
        wait_drain();
        assert (illegal_count == start_count + 4)
        else
        begin
            $display("illegal_instr pulsed %0d times for 4 illegal words.",
                     illegal_count - start_count);
            check_errors++;
        end
    endtask

    task automatic random_branch();
        logic [31:0] r;
        logic [31:0] word;
        logic [31:0] pc;
        logic [31:0] crv;
        logic [31:0] lrv;
        logic [31:0] ctrv;
        logic [4:0]  bo;
        r  = $urandom;
        bo = r[9:5];
        case (r[1:0])
            2'd0:    word = b_word(r[31:8], r[2], r[3]);
            2'd1:    word = bc_word(bo, r[14:10], r[31:18], 1'b0, r[3]);
            2'd2:    word = bclr_word(bo, r[14:10], r[3]);
            default: word = bcctr_word(bo | 5'b00100, r[14:10], r[3]);
        endcase
        pc       = $urandom;
        pc[1:0]  = 2'b00;
        crv      = $urandom;
        lrv      = $urandom;
        ctrv     = $urandom;
        // Small counts reach zero often.
        if (r[4])
            ctrv = {29'h0, r[17:15]};
        send_instr(word, pc, crv, lrv, ctrv, 1'b1);
    endtask

    task automatic backpressure_run();
        int start_idx;
        start_idx  = expected_q.size();
        ready_mode = 2;
        for (int i = 0; i < 6; i++)
            random_branch();
        wait_for_stall();
        ready_mode = 1;
        for (int i = 0; i < 6; i++)
            random_branch();
        ready_mode = 0;
        wait_drain();
        assert (check_idx == start_idx + 12)
        else
        begin
            $display("Only %0d of 12 results arrived under back-pressure.",
                     check_idx - start_idx);
            check_errors++;
        end
    endtask

    initial
    begin
        void'($urandom(32'h5a0c));
        rst_n          = 1'b0;
        instr_valid    = 1'b0;
        instr          = 32'h0;
        cia            = 32'h0;
        cr             = 32'h0;
        lr             = 32'h0;
        ctr            = 32'h0;
        ready_mode     = 0;
        check_errors   = 0;
        timeout_errors = 0;
        apply_reset();
        unconditional_branches();
        conditional_branches();
        register_targets();
        illegal_words();
        backpressure_run();
        $display("Errors: %0d result, %0d check, %0d timeout",
                 monitor_errors, check_errors, timeout_errors);
        if (monitor_errors + check_errors + timeout_errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/ppc_types.sv
rtl/branch_decoder.sv
rtl/branch_issue_fifo.sv
rtl/branch_unit.sv
rtl/branch_subsystem.sv
bench/branch_subsystem_props.sv
bench/branch_subsystem_tb.sv

//--- rtl/branch_decoder.sv
`timescale 1ns/1ps

module branch_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    output logic                     instr_ready,
    input  logic [0:31]              instr,
    input  logic [0:31]              cia,
    input  logic [0:31]              cr,
    input  logic [0:31]              lr,
    input  logic [0:31]              ctr,
    output logic                     dec_valid,
    input  logic                     dec_ready,
    output ppc_types::branch_issue_t dec_issue,
    output logic                     illegal_instr
);
    import ppc_types::*;

    ppc_opcode_t          opcode;
    logic [0:9]           xo;
    logic [0:4]           bi;
    logic [0:4]           field_base;
    logic [0:3]           cond_field;
    branch_inner_decode_t ctrl;
    logic                 legal;
    logic                 accept;

    // --------------------------------------------------
    // Field split
    // --------------------------------------------------

    assign opcode = ppc_opcode_t'(instr[0:5]);
    assign xo     = instr[21:30];
    assign bi     = instr[11:15];

    // BI bits 0 to 2 pick one of the eight 4-bit CR fields.
    assign field_base = {bi[0:2], 2'b00};
    assign cond_field = cr[field_base +: 4];

    // Map the word to an operation; unused fields stay zero.
    always_comb
    begin
        ctrl  = '0;
        legal = 1'b1;
        case (opcode)
            OP_B:
            begin
                ctrl.operation = BRANCH;
                ctrl.li        = instr[6:29];
                ctrl.aa        = instr[30];
                ctrl.lk        = instr[31];
            end
            OP_BC:
            begin
                ctrl.operation = BRANCH_CONDITIONAL;
                ctrl.bo        = instr[6:10];
                ctrl.bi_bit    = bi[3:4];
                ctrl.bd        = instr[16:29];
                ctrl.aa        = instr[30];
                ctrl.lk        = instr[31];
            end
            OP_XL:
            begin
                ctrl.bo     = instr[6:10];
                ctrl.bi_bit = bi[3:4];
                ctrl.lk     = instr[31];
                if (xo == XO_BCLR)
                begin
                    ctrl.operation = BRANCH_CONDITIONAL_LINK;
                end
                else if (xo == XO_BCCTR)
                begin
                    ctrl.operation = BRANCH_CONDITIONAL_COUNT;
                    // A count decrement has no meaning with CTR as target.
                    legal = instr[8];
                end
                else
                begin
                    legal = 1'b0;
                end
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase
    end

    // --------------------------------------------------
    // Output stage
    // --------------------------------------------------

    // Stage takes a new word when empty or draining this cycle.
    assign instr_ready = !dec_valid || dec_ready;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dec_valid     <= 1'b0;
            illegal_instr <= 1'b0;
        end
        else
        begin
            // One-cycle pulse per dropped word.
            illegal_instr <= accept && !legal;
            if (accept)
            begin
                dec_valid <= legal;
            end
            else if (dec_ready)
            begin
                dec_valid <= 1'b0;
            end
        end
    end

    // Record and register snapshot.
    always_ff @(posedge clk)
    begin
        if (accept && legal)
        begin
            dec_issue.control   <= ctrl;
            dec_issue.cia       <= cia;
            dec_issue.cond_reg  <= cond_field;
            dec_issue.link_reg  <= lr;
            dec_issue.count_reg <= ctr;
        end
    end

endmodule

//--- rtl/branch_issue_fifo.sv
`timescale 1ns/1ps

module branch_issue_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dec_valid,
    output logic                     dec_ready,
    input  ppc_types::branch_issue_t dec_issue,
    output logic                     iss_valid,
    input  logic                     iss_ready,
    output ppc_types::branch_issue_t iss_issue
);
    import ppc_types::*;

    branch_issue_t          mem [ISSUE_DEPTH];
    logic [ISSUE_PTR_W-1:0] wr_ptr;
    logic [ISSUE_PTR_W-1:0] rd_ptr;
    logic [ISSUE_CNT_W-1:0] count;
    logic                   push;
    logic                   pop;

    // --------------------------------------------------
    // Flags and handshakes
    // --------------------------------------------------

    // Full only when every entry holds a record.
    assign dec_ready = (count != ISSUE_CNT_W'(ISSUE_DEPTH));
    assign iss_valid = (count != '0);

    assign push = dec_valid && dec_ready;
    assign pop  = iss_valid && iss_ready;

    // Head entry straight from storage.
    assign iss_issue = mem[rd_ptr];

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == ISSUE_PTR_W'(ISSUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == ISSUE_PTR_W'(ISSUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count as is.
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage write.
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= dec_issue;
        end
    end

endmodule

//--- rtl/branch_subsystem.sv
`timescale 1ns/1ps

module branch_subsystem (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    output logic                      instr_ready,
    input  logic [0:31]               instr,
    input  logic [0:31]               cia,
    input  logic [0:31]               cr,
    input  logic [0:31]               lr,
    input  logic [0:31]               ctr,
    output logic                      result_valid,
    input  logic                      result_ready,
    output ppc_types::branch_result_t result,
    output logic                      speculative,
    output logic                      clear_speculative,
    output logic                      flush_speculative,
    output logic                      illegal_instr
);
    import ppc_types::*;

    // --------------------------------------------------
    // Stage links
    // --------------------------------------------------

    // Decoder to queue.
    logic          dec_valid;
    logic          dec_ready;
    branch_issue_t dec_issue;

    // Queue to branch unit.
    logic          iss_valid;
    logic          iss_ready;
    branch_issue_t iss_issue;

    branch_decoder i_branch_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .instr         (instr),
        .cia           (cia),
        .cr            (cr),
        .lr            (lr),
        .ctr           (ctr),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .dec_issue     (dec_issue),
        .illegal_instr (illegal_instr)
    );

    branch_issue_fifo i_branch_issue_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_issue (dec_issue),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss_issue (iss_issue)
    );

    branch_unit i_branch_unit (
        .clk               (clk),
        .rst_n             (rst_n),
        .iss_valid         (iss_valid),
        .iss_ready         (iss_ready),
        .iss_issue         (iss_issue),
        .result_valid      (result_valid),
        .result_ready      (result_ready),
        .result            (result),
        .speculative       (speculative),
        .clear_speculative (clear_speculative),
        .flush_speculative (flush_speculative)
    );

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      iss_valid,
    output logic                      iss_ready,
    input  ppc_types::branch_issue_t  iss_issue,
    output logic                      result_valid,
    input  logic                      result_ready,
    output ppc_types::branch_result_t result,
    // High while a conditional branch waits at the output.
    output logic                      speculative,
    // Fall-through guess was right.
    output logic                      clear_speculative,
    // Fall-through guess was wrong.
    output logic                      flush_speculative
);
    import ppc_types::*;

    branch_inner_decode_t ctl;
    logic [0:31]          seq_addr;
    logic [0:31]          rel_base;
    logic [0:31]          li_ext;
    logic [0:31]          bd_ext;
    logic                 decrement;
    logic [0:31]          ctr_next;
    logic                 ctr_ok;
    logic                 cond_ok;
    logic                 taken;
    logic [0:31]          target;
    branch_result_t       next_result;
    branch_op_t           held_op;
    logic                 accept;
    logic                 handoff;

    assign ctl = iss_issue.control;

    // --------------------------------------------------
    // Resolve
    // --------------------------------------------------

    // Address of the next sequential word.
    assign seq_addr = iss_issue.cia + 32'd4;

    // Relative targets add the branch's own address.
    assign rel_base = ctl.aa ? '0 : iss_issue.cia;

    // Word displacements, sign-extended to a byte offset.
    assign li_ext = {{6{ctl.li[0]}}, ctl.li, 2'b00};
    assign bd_ext = {{16{ctl.bd[0]}}, ctl.bd, 2'b00};

    // BO bit 2 clear asks for a CTR decrement, never on bcctr.
    assign decrement = (ctl.operation != BRANCH)
                    && (ctl.operation != BRANCH_CONDITIONAL_COUNT)
                    && !ctl.bo[2];
    assign ctr_next  = decrement ? iss_issue.count_reg - 32'd1 : iss_issue.count_reg;

    // BO bit 3 picks branch on zero or on nonzero.
    assign ctr_ok  = ctl.bo[2] || ((ctr_next != '0) != ctl.bo[3]);
    // BO bit 0 ignores the CR bit, else it must equal BO bit 1.
    assign cond_ok = ctl.bo[0] || (iss_issue.cond_reg[ctl.bi_bit] == ctl.bo[1]);

    always_comb
    begin
        case (ctl.operation)
            BRANCH:
            begin
                target = li_ext + rel_base;
                taken  = 1'b1;
            end
            BRANCH_CONDITIONAL:
            begin
                target = bd_ext + rel_base;
                taken  = ctr_ok && cond_ok;
            end
            BRANCH_CONDITIONAL_LINK:
            begin
                // Word aligned link target.
                target = {iss_issue.link_reg[0:29], 2'b00};
                taken  = ctr_ok && cond_ok;
            end
            default:
            begin
                target = {iss_issue.count_reg[0:29], 2'b00};
                taken  = ctr_ok && cond_ok;
            end
        endcase
    end

    assign next_result.nia       = taken ? target : seq_addr;
    assign next_result.link_reg  = ctl.lk ? seq_addr : iss_issue.link_reg;
    assign next_result.count_reg = ctr_next;
    assign next_result.taken     = taken;

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------

    assign iss_ready = !result_valid || result_ready;
    assign accept    = iss_valid && iss_ready;
    assign handoff   = result_valid && result_ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result_valid <= 1'b0;
        end
        else if (accept)
        begin
            result_valid <= 1'b1;
        end
        else if (result_ready)
        begin
            result_valid <= 1'b0;
        end
    end

    // Result payload and the operation that made it.
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            result  <= next_result;
            held_op <= ctl.operation;
        end
    end

    // Speculation signals.
    assign speculative       = result_valid && (held_op != BRANCH);
    assign clear_speculative = handoff && speculative && !result.taken;
    assign flush_speculative = handoff && speculative && result.taken;

endmodule

//--- rtl/ppc_types.sv
package ppc_types;

    // --------------------------------------------------
    // Instruction encoding
    // --------------------------------------------------

    // Primary opcodes of the branch forms, instruction bits 0 to 5.
    typedef enum logic [0:5] {
        OP_BC = 6'd16,
        OP_B  = 6'd18,
        OP_XL = 6'd19
    } ppc_opcode_t;

    // Extended opcodes of the XL form, instruction bits 21 to 30.
    localparam logic [0:9] XO_BCLR  = 10'd16;
    localparam logic [0:9] XO_BCCTR = 10'd528;

    // Branch operation resolved by the decoder.
    typedef enum logic [1:0] {
        BRANCH                   = 2'd0,
        BRANCH_CONDITIONAL       = 2'd1,
        BRANCH_CONDITIONAL_LINK  = 2'd2,
        BRANCH_CONDITIONAL_COUNT = 2'd3
    } branch_op_t;

    // --------------------------------------------------
    // Records between the stages
    // --------------------------------------------------

    // Decoded branch fields, big-endian numbering as in the word.
    typedef struct packed {
        branch_op_t  operation;
        // Word displacement of the I form.
        logic [0:23] li;
        // Absolute target.
        logic        aa;
        // Write the link register.
        logic        lk;
        // Branch options.
        logic [0:4]  bo;
        // Bit inside the selected condition field.
        logic [0:1]  bi_bit;
        // Word displacement of the B form.
        logic [0:13] bd;
    } branch_inner_decode_t;

    // One queue entry, with the register snapshot taken at decode.
    typedef struct packed {
        branch_inner_decode_t control;
        logic [0:31]          cia;
        logic [0:3]           cond_reg;
        logic [0:31]          link_reg;
        logic [0:31]          count_reg;
    } branch_issue_t;

    // Resolved branch as it leaves the unit.
    typedef struct packed {
        logic [0:31] nia;
        logic [0:31] link_reg;
        logic [0:31] count_reg;
        logic        taken;
    } branch_result_t;

    // Issue queue sizing.
    localparam int ISSUE_DEPTH = 4;
    localparam int ISSUE_PTR_W = $clog2(ISSUE_DEPTH);
    localparam int ISSUE_CNT_W = ISSUE_PTR_W + 1;

endpackage
